/* Makefile */
# Verilator build and run of the stepper controller testbench

TOP = tb_mcoi_application

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# the simulation passes only if the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^All checks passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/mcoi_golden.txt */
// feedback_motordata_page_pfailn_swan_swbn_pins{clk,dir,en,boost}_pageword
// page 0 shows the interlock state before the frame, motor pages the previous masks
00000000_0123456789ABCDEF_00_FFFF_FFFF_FFFF_FFFFFFFFFFFFFFFF_00000001
5A5AC3C3_0123456789ABCDEF_00_FFFF_FFFF_FFFF_00FF33330F0F5555_00000001
5A5AC3C3_0000000000000000_00_FFFE_FFFF_FFFF_0000000000000000_80000001
5A5AC3C3_8888888888888888_01_FFFF_FFFD_FFFB_FFFF000000000000_22010007
5A5AC3C3_4444444444444444_02_7FFF_7FFF_7FFF_00000000FFFF0000_0000000A
5A5AC3C3_2222222222222222_03_FFFF_00FF_FF00_0000FFFF00000000_11112222
5A5AC3C3_1111111111111111_04_AAAA_FFFF_FFFF_000000000000FFFF_33334444
5A5AC3C3_FFFFFFFFFFFFFFFF_10_00FF_0F0F_5555_FFFFFFFFFFFFFFFF_00000004
5A5AC3C3_0123456789ABCDEF_11_00FF_0F0F_5555_00FF33330F0F5555_00000002
5A5AC3C3_0123456789ABCDEF_12_00FF_0F0F_5555_00FF33330F0F5555_00000000
5A5AC3C3_0123456789ABCDEF_13_00FF_0F0F_5555_00FF33330F0F5555_00000002
5A5AC3C3_0123456789ABCDEF_14_00FF_0F0F_5555_00FF33330F0F5555_00000001
5A5AC3C3_0123456789ABCDEF_15_00FF_0F0F_5555_00FF33330F0F5555_00000003
5A5AC3C3_0123456789ABCDEF_16_00FF_0F0F_5555_00FF33330F0F5555_00000001
5A5AC3C3_0123456789ABCDEF_17_00FF_0F0F_5555_00FF33330F0F5555_00000003
5A5AC3C3_0123456789ABCDEF_18_00FF_0F0F_5555_00FF33330F0F5555_00000004
5A5AC3C3_0123456789ABCDEF_19_00FF_0F0F_5555_00FF33330F0F5555_00000006
5A5AC3C3_0123456789ABCDEF_1A_00FF_0F0F_5555_00FF33330F0F5555_00000004
5A5AC3C3_0123456789ABCDEF_1B_00FF_0F0F_5555_00FF33330F0F5555_00000006
5A5AC3C3_0123456789ABCDEF_1C_00FF_0F0F_5555_00FF33330F0F5555_00000005
5A5AC3C3_0123456789ABCDEF_1D_00FF_0F0F_5555_00FF33330F0F5555_00000007
5A5AC3C3_0123456789ABCDEF_1E_00FF_0F0F_5555_00FF33330F0F5555_00000005
5A5AC3C3_0123456789ABCDEF_1F_00FF_0F0F_5555_00FF33330F0F5555_00000007
5A5AC3C3_0123456789ABCDEF_20_00FF_0F0F_5555_00FF33330F0F5555_DEADBEEF
5A5AC3C2_0000000000000000_05_FFFF_FFFF_FFFF_FFFFFFFFFFFFFFFF_DEADBEEF
5A5AC3C2_0000000000000000_00_FFFF_FFFF_FFFF_FFFFFFFFFFFFFFFF_00000001

/* dv/tb_mcoi_application.sv */
//----------------------------------------------------------------------
// stepper controller application testbench
// replays golden link frames and checks pins, pages and status words,
// then exercises the interlock with random data and the step LEDs
//----------------------------------------------------------------------

`include "mcoi_settings.svh"

module tb_mcoi_application;

   localparam int MAX_VECTORS = 64;

   logic        gbt_rx_clkrs;
   logic        rst_n_i;
   logic        rx_clken_i;
   logic [31:0] feedback_i;
   logic [63:0] motor_data_i;
   logic [7:0]  page_select_i;
   logic [3:0]  pcb_rev_i;
   logic [15:0] pl_pfail_n_i;
   logic [15:0] pl_sw_outa_n_i;
   logic [15:0] pl_sw_outb_n_i;
   logic [15:0] pl_clk_o;
   logic [15:0] pl_dir_o;
   logic [15:0] pl_en_o;
   logic [15:0] pl_boost_o;
   logic [15:0] step_led_o;
   logic [63:0] status_word_o;
   logic [31:0] page_word_o;
   logic        link_led_o;

   // one golden vector holds feedback, motor data, page, the three pin
   // masks, the expected pins {clk, dir, en, boost} and the page word
   logic [247:0] vectors [0:MAX_VECTORS-1];
   int           num_vectors = 0;
   int           checks = 0;
   int           errors = 0;
   int           seed = 32'hd165;

   mcoi_application dut (.*);

   initial begin
      gbt_rx_clkrs = 1'b0;
      forever #2 gbt_rx_clkrs = ~gbt_rx_clkrs;
   end

   //-------------------------------------------------------------------
   // helpers
   //-------------------------------------------------------------------

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // inputs change one time unit after the edge, outputs are read there too
   task automatic next_cycle();
      @(posedge gbt_rx_clkrs);
      #1;
   endtask

   // a frame lasts one cycle, the strobe drops again right after it
   task automatic send_frame(input logic [31:0] fb, input logic [63:0] md,
                             input logic [7:0] page);
      feedback_i    = fb;
      motor_data_i  = md;
      page_select_i = page;
      rx_clken_i    = 1'b1;
      next_cycle();
      rx_clken_i    = 1'b0;
   endtask

   // each nibble is {step_out, deactivate, dir, boost}, motor 0 lowest
   function automatic logic [63:0] expected_pins(input logic [63:0] md);
      logic [15:0] clk;
      logic [15:0] dir;
      logic [15:0] en;
      logic [15:0] boost;
      for (int m = 0; m < 16; m++) begin
         clk[m]   = md[4*m+3];
         en[m]    = md[4*m+2];
         dir[m]   = md[4*m+1];
         boost[m] = md[4*m];
      end
      return {clk, dir, en, boost};
   endfunction

   // status nibble is {overheat, pfail, switch B, switch A}, all active high
   function automatic logic [63:0] expected_status(input logic [15:0] pf,
                                                    input logic [15:0] sa,
                                                    input logic [15:0] sb);
      logic [63:0] word;
      for (int m = 0; m < 16; m++) begin
         word[4*m +: 4] = {1'b0, ~pf[m], ~sb[m], ~sa[m]};
      end
      return word;
   endfunction

   task automatic run_vector(input int idx);
      logic [247:0] v;
      v = vectors[idx];
      pl_pfail_n_i   = v[143:128];
      pl_sw_outa_n_i = v[127:112];
      pl_sw_outb_n_i = v[111:96];
      send_frame(v[247:216], v[215:152], v[151:144]);
      check_value($sformatf("vector %0d pins", idx), v[95:32],
                  {pl_clk_o, pl_dir_o, pl_en_o, pl_boost_o});
      check_value($sformatf("vector %0d page", idx), v[31:0], page_word_o);
      // three synchronizer stages plus the readback register
      repeat (5) next_cycle();
      check_value($sformatf("vector %0d status", idx),
                  expected_status(v[143:128], v[127:112], v[111:96]), status_word_o);
   endtask

   // counts the cycles with every step LED lit, the pulse is bounded
   task automatic count_led_cycles(input string name);
      int n;
      n = 0;
      for (int c = 0; c < 4 * `MCOI_STEP_LED_CYCLES; c++) begin
         next_cycle();
         if (step_led_o !== 16'hFFFF) break;
         n++;
      end
      check_value({name, " length"}, `MCOI_STEP_LED_CYCLES, n);
      check_value({name, " off"}, 64'h0, step_led_o);
   endtask

   //-------------------------------------------------------------------
   // test sequence
   //-------------------------------------------------------------------

   initial begin
      logic [63:0] rand_data;
      rst_n_i        = 1'b0;
      rx_clken_i     = 1'b0;
      feedback_i     = '0;
      motor_data_i   = '0;
      page_select_i  = '0;
      pcb_rev_i      = 4'hA;
      pl_pfail_n_i   = '1;
      pl_sw_outa_n_i = '1;
      pl_sw_outb_n_i = '1;
      // entries beyond the end of the file keep a marker built from their index
      for (int i = 0; i < MAX_VECTORS; i++) begin
         vectors[i] = {{240{1'b1}}, 8'(i)};
      end
      $readmemh("dv/mcoi_golden.txt", vectors);
      while (num_vectors < MAX_VECTORS &&
             vectors[num_vectors] !== {{240{1'b1}}, 8'(num_vectors)}) begin
         num_vectors++;
      end
      repeat (2) @(posedge gbt_rx_clkrs);
      #1;
      rst_n_i = 1'b1;

      // out of reset every motor is deactivated and the loop is open
      check_value("reset pins", 64'hFFFF_FFFF_FFFF_FFFF,
                  {pl_clk_o, pl_dir_o, pl_en_o, pl_boost_o});
      check_value("reset link led", 64'h1, link_led_o);
      check_value("reset page", 64'h0, page_word_o);
      check_value("reset leds", 64'h0, step_led_o);

      if (num_vectors == 0) begin
         errors++;
         $display("no golden vectors could be read from dv/mcoi_golden.txt");
      end
      for (int i = 0; i < num_vectors; i++) begin
         run_vector(i);
      end

      // closing the loop with arbitrary motor data
      rand_data = {$random(seed), $random(seed)};
      send_frame(`MCOI_INTERLOCK_KEY, rand_data, 8'd1);
      check_value("random pins", expected_pins(rand_data),
                  {pl_clk_o, pl_dir_o, pl_en_o, pl_boost_o});
      check_value("random link led", 64'h0, link_led_o);

      // one falling edge on every step line
      send_frame(`MCOI_INTERLOCK_KEY, 64'h8888_8888_8888_8888, 8'd0);
      send_frame(`MCOI_INTERLOCK_KEY, 64'h0, 8'd0);
      count_led_cycles("single led pulse");

      // a second edge two cycles into the pulse starts it over
      send_frame(`MCOI_INTERLOCK_KEY, 64'h8888_8888_8888_8888, 8'd0);
      send_frame(`MCOI_INTERLOCK_KEY, 64'h0, 8'd0);
      send_frame(`MCOI_INTERLOCK_KEY, 64'h8888_8888_8888_8888, 8'd0);
      send_frame(`MCOI_INTERLOCK_KEY, 64'h0, 8'd0);
      count_led_cycles("restarted led pulse");

      $display("%0d checks run, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // the budget scales with the number of golden vectors
   initial begin
      @(posedge rst_n_i);
      repeat (num_vectors * 20 + 200) @(posedge gbt_rx_clkrs);
      $display("timeout, the run did not finish within %0d clock cycles",
               num_vectors * 20 + 200);
      $display("Checks failed");
      $finish;
   end

endmodule

/* hw/mcoi_application.sv */
//----------------------------------------------------------------------
// stepper controller application
// receive-side top level behind the optical link, captures motor
// control, runs the motor channels and builds the readback words
//----------------------------------------------------------------------

`include "mcoi_settings.svh"

module mcoi_application (
   input  logic                        gbt_rx_clkrs,
   input  logic                        rst_n_i,
   // link frame strobe and payload
   input  logic                        rx_clken_i,
   input  logic [31:0]                 feedback_i,
   input  logic [63:0]                 motor_data_i,
   input  logic [7:0]                  page_select_i,
   // board revision straps
   input  logic [3:0]                  pcb_rev_i,
   // active-low driver status pins
   input  logic [`MCOI_NUM_MOTORS-1:0] pl_pfail_n_i,
   input  logic [`MCOI_NUM_MOTORS-1:0] pl_sw_outa_n_i,
   input  logic [`MCOI_NUM_MOTORS-1:0] pl_sw_outb_n_i,
   // driver control pins and step LEDs
   output logic [`MCOI_NUM_MOTORS-1:0] pl_clk_o,
   output logic [`MCOI_NUM_MOTORS-1:0] pl_dir_o,
   output logic [`MCOI_NUM_MOTORS-1:0] pl_en_o,
   output logic [`MCOI_NUM_MOTORS-1:0] pl_boost_o,
   output logic [`MCOI_NUM_MOTORS-1:0] step_led_o,
   // words returned over the link
   output logic [63:0]                 status_word_o,
   output logic [31:0]                 page_word_o,
   output logic                        link_led_o
);

   // shared state of all motors
   mcoi_motor_bus_if bus ();

   // interlock check and capture of the control word on each frame
   mcoi_link_capture i_link_capture (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_n_i      (rst_n_i),
      .rx_clken_i   (rx_clken_i),
      .feedback_i   (feedback_i),
      .motor_data_i (motor_data_i),
      .bus          (bus.capture_mp)
   );

   //-------------------------------------------------------------------
   // motor channels, one per driver
   //-------------------------------------------------------------------

   for (genvar i = 0; i < `MCOI_NUM_MOTORS; i++) begin : g_motor
      mcoi_motor_channel i_channel (
         .gbt_rx_clkrs   (gbt_rx_clkrs),
         .rst_n_i        (rst_n_i),
         .ctrl_i         (bus.ctrl[i]),
         .pl_clk_o       (pl_clk_o[i]),
         .pl_dir_o       (pl_dir_o[i]),
         .pl_en_o        (pl_en_o[i]),
         .pl_boost_o     (pl_boost_o[i]),
         .pl_pfail_n_i   (pl_pfail_n_i[i]),
         .pl_sw_outa_n_i (pl_sw_outa_n_i[i]),
         .pl_sw_outb_n_i (pl_sw_outb_n_i[i]),
         .status_o       (bus.status[i]),
         .step_led_o     (bus.step_led[i])
      );
   end

   assign step_led_o = bus.step_led;

   // status word and diagnostic pages back towards the link
   mcoi_status_readback i_status_readback (
      .gbt_rx_clkrs  (gbt_rx_clkrs),
      .rst_n_i       (rst_n_i),
      .rx_clken_i    (rx_clken_i),
      .page_select_i (page_select_i),
      .pcb_rev_i     (pcb_rev_i),
      .bus           (bus.readback_mp),
      .status_word_o (status_word_o),
      .page_word_o   (page_word_o),
      .link_led_o    (link_led_o)
   );

endmodule

/* hw/mcoi_link_capture.sv */
//----------------------------------------------------------------------
// link capture
// checks the returned feedback word against the interlock key on each
// frame and latches the motor control word, or deactivates all motors
//----------------------------------------------------------------------

`include "mcoi_settings.svh"

module mcoi_link_capture (
   input  logic                      gbt_rx_clkrs,
   input  logic                      rst_n_i,
   input  logic                      rx_clken_i,
   input  logic [31:0]               feedback_i,
   input  logic [63:0]               motor_data_i,
   mcoi_motor_bus_if.capture_mp      bus
);

   // the loop counts as closed only when the far end echoes the key
   logic key_match;

   assign key_match = (feedback_i == `MCOI_INTERLOCK_KEY);

   //-------------------------------------------------------------------
   // frame capture
   //-------------------------------------------------------------------

   // a frame is any cycle with rx_clken_i high, there is no back-pressure
   // between frames the captured word and the flag simply hold
   always_ff @(posedge gbt_rx_clkrs or negedge rst_n_i) begin
      if (!rst_n_i) begin
         // all ones deactivates every driver and parks the step line high
         bus.ctrl         <= '1;
         bus.interlock_ok <= 1'b0;
      end else if (rx_clken_i) begin
         if (key_match) begin
            // motor 0 takes the lowest nibble of the link word
            bus.ctrl         <= motor_data_i;
            bus.interlock_ok <= 1'b1;
         end else begin
            // an open loop must never let a motor step
            // so a bad key drops every motor back to the deactivated word
            bus.ctrl         <= '1;
            bus.interlock_ok <= 1'b0;
         end
      end
   end

   //-------------------------------------------------------------------
   // checks
   //-------------------------------------------------------------------

   // a frame carrying the wrong key must leave all motors deactivated
   // on the next cycle, whatever was captured before
   a_open_loop_deactivates : assert property (
      @(posedge gbt_rx_clkrs) disable iff (!rst_n_i)
      (rx_clken_i && !key_match) |=> (bus.ctrl == '1) && !bus.interlock_ok
   );

endmodule

/* hw/mcoi_motor_bus_if.sv */
//----------------------------------------------------------------------
// motor bus
// carries control, status and LED state of all motors between the link
// capture, the motor channels and the readback block
//----------------------------------------------------------------------

`include "mcoi_settings.svh"

interface mcoi_motor_bus_if;

   import mcoi_pkg::*;

   // control nibble per motor, motor 0 in the low entry
   motor_ctrl_t   [`MCOI_NUM_MOTORS-1:0] ctrl;
   // synchronized status nibble per motor
   motor_status_u [`MCOI_NUM_MOTORS-1:0] status;
   // stretched step indication per motor
   logic          [`MCOI_NUM_MOTORS-1:0] step_led;
   // high while the feedback loop is closed
   logic                                 interlock_ok;

   // the link side owns the control word and the interlock flag
   modport capture_mp (output ctrl, output interlock_ok);

   // each channel takes its control and returns its status and LED
   modport channel_mp (input ctrl, output status, output step_led);

   // the readback side only observes
   modport readback_mp (input status, input interlock_ok);

endinterface

/* hw/mcoi_motor_channel.sv */
//----------------------------------------------------------------------
// motor channel
// maps one motor's control nibble to its driver pins, synchronizes the
// active-low driver status pins and stretches step pulses for the LED
//----------------------------------------------------------------------

`include "mcoi_settings.svh"

module mcoi_motor_channel (
   input  logic                  gbt_rx_clkrs,
   input  logic                  rst_n_i,
   input  mcoi_pkg::motor_ctrl_t ctrl_i,
   output logic                  pl_clk_o,
   output logic                  pl_dir_o,
   output logic                  pl_en_o,
   output logic                  pl_boost_o,
   input  logic                  pl_pfail_n_i,
   input  logic                  pl_sw_outa_n_i,
   input  logic                  pl_sw_outb_n_i,
   output mcoi_pkg::motor_status_u status_o,
   output logic                  step_led_o
);

   localparam int unsigned LED_CNT_W = $clog2(`MCOI_STEP_LED_CYCLES + 1);

   // inverted status pins, pfail on top and switch A at the bottom
   logic [2:0]                             pin_active;
   logic [`MCOI_SYNC_STAGES-1:0][2:0]      sync_q;
   logic                                   step_out_q;
   logic [LED_CNT_W-1:0]                   led_cnt;

   //-------------------------------------------------------------------
   // driver pins
   //-------------------------------------------------------------------

   // pins follow the captured word directly, so they move one cycle
   // after the frame that changed it
   // the enable pin of this driver is active low, hence deactivate
   assign pl_clk_o   = ctrl_i.step_out;
   assign pl_dir_o   = ctrl_i.dir;
   assign pl_en_o    = ctrl_i.deactivate;
   assign pl_boost_o = ctrl_i.boost;

   //-------------------------------------------------------------------
   // status synchronizer
   //-------------------------------------------------------------------

   // driver outputs are active low and asynchronous to the link clock
   assign pin_active = {~pl_pfail_n_i, ~pl_sw_outb_n_i, ~pl_sw_outa_n_i};

   // a pin change reaches the last stage after MCOI_SYNC_STAGES edges
   // reset value reads as no fault and no switch hit
   always_ff @(posedge gbt_rx_clkrs or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[`MCOI_SYNC_STAGES-2:0], pin_active};
      end
   end

   always_comb begin
      status_o.fields.overheat     = 1'b0;
      status_o.fields.pfail        = sync_q[`MCOI_SYNC_STAGES-1][2];
      status_o.fields.raw_switches = sync_q[`MCOI_SYNC_STAGES-1][1:0];
   end

   //-------------------------------------------------------------------
   // step LED stretcher
   //-------------------------------------------------------------------

   // the driver steps on the falling edge of its clock pin, so that is
   // the edge shown on the LED
   // step_out idles high after reset, matching the deactivated word
   always_ff @(posedge gbt_rx_clkrs or negedge rst_n_i) begin
      if (!rst_n_i) begin
         step_out_q <= 1'b1;
         led_cnt    <= '0;
      end else begin
         step_out_q <= ctrl_i.step_out;
         if (step_out_q && !ctrl_i.step_out) begin
            // a new edge restarts the pulse even if one is running
            led_cnt <= LED_CNT_W'(`MCOI_STEP_LED_CYCLES);
         end else if (led_cnt != '0) begin
            led_cnt <= led_cnt - LED_CNT_W'(1);
         end
      end
   end

   // lit for exactly MCOI_STEP_LED_CYCLES cycles after the edge is seen
   assign step_led_o = (led_cnt != '0);

   // the reload value is the only way up, so the count stays in range
   a_led_cnt_range : assert property (
      @(posedge gbt_rx_clkrs) disable iff (!rst_n_i)
      led_cnt <= LED_CNT_W'(`MCOI_STEP_LED_CYCLES)
   );

endmodule

/* hw/mcoi_pkg.sv */
//----------------------------------------------------------------------
// stepper controller types
// per-motor control nibble and the status nibble with its two views
//----------------------------------------------------------------------

package mcoi_pkg;

   //-------------------------------------------------------------------
   // control nibble, as received in the 64-bit motor word
   //-------------------------------------------------------------------

   // step_out sits in the top bit and boost in the bottom bit
   // all ones means the driver is deactivated and the step line idles high
   typedef struct packed {
      logic step_out;
      logic deactivate;
      logic dir;
      logic boost;
   } motor_ctrl_t;

   //-------------------------------------------------------------------
   // status nibble, as sent back in the 64-bit readback word
   //-------------------------------------------------------------------

   // decoded view used by the motor channel
   // overheat is not wired on this board and always reads 0
   // raw_switches[0] is extremity switch A, raw_switches[1] is switch B
   typedef struct packed {
      logic       overheat;
      logic       pfail;
      logic [1:0] raw_switches;
   } motor_status_fields_t;

   // the same four bits seen either as fields or as a plain nibble
   // the readback pages only ever need the nibble
   typedef union packed {
      motor_status_fields_t fields;
      logic [3:0]           raw;
   } motor_status_u;

endpackage

/* hw/mcoi_status_readback.sv */
//----------------------------------------------------------------------
// status readback
// packs the synchronized motor statuses into the returned link word and
// serves one page-selected diagnostic word per frame
//----------------------------------------------------------------------

`include "mcoi_settings.svh"

module mcoi_status_readback (
   input  logic                      gbt_rx_clkrs,
   input  logic                      rst_n_i,
   input  logic                      rx_clken_i,
   input  logic [7:0]                page_select_i,
   input  logic [3:0]                pcb_rev_i,
   mcoi_motor_bus_if.readback_mp     bus,
   output logic [63:0]               status_word_o,
   output logic [31:0]               page_word_o,
   output logic                      link_led_o
);

   // pages 16 to 31 address one motor each with the low nibble
   logic        motor_page;
   logic [3:0]  motor_sel;

   assign motor_page = (page_select_i[7:4] == 4'h1);
   assign motor_sel  = page_select_i[3:0];

   //-------------------------------------------------------------------
   // returned status word
   //-------------------------------------------------------------------

   // one nibble per motor, motor 0 in the lowest bits
   // refreshed every cycle, not only on frames
   always_ff @(posedge gbt_rx_clkrs or negedge rst_n_i) begin
      if (!rst_n_i) begin
         status_word_o <= '0;
      end else begin
         for (int m = 0; m < `MCOI_NUM_MOTORS; m++) begin
            status_word_o[4*m +: 4] <= bus.status[m].raw;
         end
      end
   end

   //-------------------------------------------------------------------
   // diagnostic pages
   //-------------------------------------------------------------------

   // the selector is sampled on a frame and the answer holds until the
   // next one, so the far end always reads a stable word
   always_ff @(posedge gbt_rx_clkrs or negedge rst_n_i) begin
      if (!rst_n_i) begin
         page_word_o <= '0;
      end else if (rx_clken_i) begin
         case (page_select_i)
            // loopback, bit 31 tells the far end the loop is closed
            8'd0: page_word_o <= {bus.interlock_ok, 30'b0, 1'b1};
            8'd1: page_word_o <= `MCOI_BUILD_NUMBER;
            8'd2: page_word_o <= {28'b0, pcb_rev_i};
            8'd3: page_word_o <= 32'(`MCOI_UNIQUE_ID >> 32);
            8'd4: page_word_o <= 32'(`MCOI_UNIQUE_ID);
            default: begin
               if (motor_page) begin
                  page_word_o <= {28'b0, bus.status[motor_sel].raw};
               end else begin
                  // unused pages are easy to spot on the far end
                  page_word_o <= 32'hDEAD_BEEF;
               end
            end
         endcase
      end
   end

   // active low, lit while the interlock is closed
   assign link_led_o = ~bus.interlock_ok;

   // outside a frame the page word is frozen
   a_page_only_on_frame : assert property (
      @(posedge gbt_rx_clkrs) disable iff (!rst_n_i)
      !$past(rx_clken_i) |-> $stable(page_word_o)
   );

endmodule

/* include/mcoi_settings.svh */
//----------------------------------------------------------------------
// stepper controller settings
// motor count, synchronizer depth, LED stretch length and the
// constants returned over the optical link
//----------------------------------------------------------------------

`ifndef MCOI_SETTINGS_SVH
`define MCOI_SETTINGS_SVH

// number of stepper motors served by one fiber
`define MCOI_NUM_MOTORS 16

// depth of the flop chain that brings driver status pins into the
// link clock domain
`define MCOI_SYNC_STAGES 3

// length of the step LED pulse in link clock cycles
// kept short for simulation, hardware needs a few million
`define MCOI_STEP_LED_CYCLES 8

// the feedback word must equal this key before any motor may move
`define MCOI_INTERLOCK_KEY 32'h5A5A_C3C3

// constants served on the diagnostic pages
`define MCOI_BUILD_NUMBER 32'h2201_0007
`define MCOI_UNIQUE_ID 64'h1111_2222_3333_4444

`endif

/* tb.f */
+incdir+include
hw/mcoi_pkg.sv
hw/mcoi_motor_bus_if.sv
hw/mcoi_link_capture.sv
hw/mcoi_motor_channel.sv
hw/mcoi_status_readback.sv
hw/mcoi_application.sv
dv/tb_mcoi_application.sv
